//--- src/uart_params.svh
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// system clocks per prescaled tick
// a small factor keeps simulation short, raise it for a real system clock
`define UART_CLK_DIV 2

// sub-ticks per bit period
`define UART_SUBTICKS 8

// width of the runtime baud divisor
`define UART_BAUD_W 8

// widest frame: start, 8 data, parity and 2 stop bits
`define UART_FRAME_MAX 12

`endif

//--- src/uart_pkg.sv
`include "uart_params.svh"

package uart_pkg;

	typedef enum logic [1:0] {
		LEN8 = 2'd0,  // eight data bits
		LEN7 = 2'd1,
		LEN6 = 2'd2,
		LEN5 = 2'd3   // five data bits
	} data_len_e;

	typedef enum logic [1:0] {
		STOP1  = 2'd0,  // one stop bit
		STOP1H = 2'd1,  // one and a half, sent as two
		STOP2  = 2'd2   // two stop bits
	} stop_len_e;

	typedef enum logic [1:0] {
		PAR_ODD   = 2'd0,  // ones in data plus parity is odd
		PAR_EVEN  = 2'd1,  // ones in data plus parity is even
		PAR_MARK  = 2'd2,  // parity bit always 1
		PAR_SPACE = 2'd3   // parity bit always 0
	} parity_e;

	// controller states
	typedef enum logic [1:0] {
		IDLE = 2'd0,  // waiting for en
		LOAD = 2'd1,  // frame captured, timer starts
		SEND = 2'd2   // bits going out on tx
	} tx_state_e;

	// line format, 7 bits
	typedef struct packed {
		data_len_e data_len;
		stop_len_e stop_len;
		logic      parity_en;
		parity_e   parity;
	} line_fmt_t;

	// assembled frame, start bit at bits[0], ones above the last stop bit
	typedef struct packed {
		logic [`UART_FRAME_MAX-1:0] bits;
		logic [3:0]                 last_bit;  // index of the last stop bit
	} frame_t;

endpackage

//--- src/uart_baud_timer.sv
`include "uart_params.svh"

module uart_baud_timer (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    run,       // count while high, clear while low
	input  logic [`UART_BAUD_W-1:0] baud_div,  // bit clock divisor minus one
	output logic                    bit_tick   // one pulse per bit period
);

	localparam int PRE_W = (`UART_CLK_DIV > 1) ? $clog2(`UART_CLK_DIV) : 1;
	localparam int SUB_W = $clog2(`UART_SUBTICKS);

	logic [PRE_W-1:0]        pre_cnt;  // system clocks within one prescaled tick
	logic [`UART_BAUD_W-1:0] div_cnt;  // prescaled ticks within one sub-tick
	logic [SUB_W-1:0]        sub_cnt;  // sub-ticks within one bit
	logic                    pre_wrap;
	logic                    div_wrap;
	logic                    sub_wrap;

	assign pre_wrap = (pre_cnt == PRE_W'(`UART_CLK_DIV - 1));
	assign div_wrap = (div_cnt == baud_div);
	assign sub_wrap = (sub_cnt == SUB_W'(`UART_SUBTICKS - 1));

	// all three counters at their last value
	assign bit_tick = run & pre_wrap & div_wrap & sub_wrap;

	always_ff @(posedge clk) begin
		if (rst || !run) begin
			pre_cnt <= '0;
			div_cnt <= '0;
			sub_cnt <= '0;
		end else if (!pre_wrap) begin
			pre_cnt <= pre_cnt + 1'b1;
		end else begin
			pre_cnt <= '0;
			if (!div_wrap) begin
				div_cnt <= div_cnt + 1'b1;
			end else begin
				div_cnt <= '0;
				if (!sub_wrap)
					sub_cnt <= sub_cnt + 1'b1;
				else
					sub_cnt <= '0;  // bit period complete
			end
		end
	end

endmodule

//--- src/uart_tx_ctrl.sv
module uart_tx_ctrl (
	input  logic       clk,
	input  logic       rst,
	input  logic       en,        // start strobe, only looked at in IDLE
	input  logic       bit_tick,  // end of one bit period
	input  logic [3:0] last_bit,  // index of the last bit in the latched frame
	output logic       load,      // capture data and format into the frame
	output logic       run,       // keeps the baud timer counting
	output logic       busy,
	output logic       ack        // one cycle at the end of the frame
);

	uart_pkg::tx_state_e state;
	uart_pkg::tx_state_e next_state;
	logic [3:0]          bit_cnt;   // bits already sent
	logic                last_tick;

	assign last_tick = (state == uart_pkg::SEND) && bit_tick && (bit_cnt == last_bit);

	// frame is taken on the edge that leaves IDLE
	assign load = (state == uart_pkg::IDLE) && en;
	assign run  = (state != uart_pkg::IDLE);
	assign ack  = last_tick;  // busy drops on the edge after this

	always_comb begin
		next_state = state;
		case (state)
			uart_pkg::IDLE: begin
				if (en)
					next_state = uart_pkg::LOAD;
			end
			uart_pkg::LOAD: begin
				next_state = uart_pkg::SEND;
			end
			uart_pkg::SEND: begin
				if (last_tick)
					next_state = uart_pkg::IDLE;
			end
			default: begin
				next_state = uart_pkg::IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= uart_pkg::IDLE;
			busy  <= 1'b0;
		end else begin
			state <= next_state;
			busy  <= (next_state != uart_pkg::IDLE);
		end
	end

	always_ff @(posedge clk) begin
		if (rst || state != uart_pkg::SEND)
			bit_cnt <= '0;
		else if (bit_tick)
			bit_cnt <= last_tick ? 4'd0 : bit_cnt + 4'd1;
	end

endmodule

//--- src/uart_frame_builder.sv
`include "uart_params.svh"

module uart_frame_builder (
	input  logic                clk,
	input  logic                rst,
	input  logic                load,   // capture strobe from the controller
	input  logic [7:0]          data,
	input  uart_pkg::line_fmt_t fmt,
	output uart_pkg::frame_t    frame
);

	logic [3:0]             n_data;     // data bits in this format
	logic [1:0]             n_stop;     // stop bits actually sent
	logic [7:0]             data_mask;
	logic [7:0]             active;     // data bits that go on the line
	logic                   par_bit;
	uart_pkg::frame_t       frame_d;
	uart_pkg::frame_t       frame_q;

	always_comb begin
		case (fmt.data_len)
			uart_pkg::LEN8: begin
				n_data    = 4'd8;
				data_mask = 8'hff;
			end
			uart_pkg::LEN7: begin
				n_data    = 4'd7;
				data_mask = 8'h7f;
			end
			uart_pkg::LEN6: begin
				n_data    = 4'd6;
				data_mask = 8'h3f;
			end
			default: begin
				n_data    = 4'd5;
				data_mask = 8'h1f;
			end
		endcase
	end

	assign active = data & data_mask;
	assign n_stop = (fmt.stop_len == uart_pkg::STOP1) ? 2'd1 : 2'd2;  // 1.5 goes out as 2

	always_comb begin
		par_bit = 1'b0;
		case (fmt.parity)
			uart_pkg::PAR_ODD:   par_bit = ~(^active);
			uart_pkg::PAR_EVEN:  par_bit = ^active;
			uart_pkg::PAR_MARK:  par_bit = 1'b1;
			uart_pkg::PAR_SPACE: par_bit = 1'b0;
			default:             par_bit = 1'b0;
		endcase
	end

	// start bit, data lsb first, optional parity, ones above
	always_comb begin
		frame_d.bits    = '1;
		frame_d.bits[0] = 1'b0;
		for (int i = 0; i < 8; i++) begin
			if (i < n_data)
				frame_d.bits[i+1] = data[i];
		end
		if (fmt.parity_en)
			frame_d.bits[n_data+1] = par_bit;
		frame_d.last_bit = n_data + {3'b000, fmt.parity_en} + {2'b00, n_stop};
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			frame_q.bits     <= '1;
			frame_q.last_bit <= '0;
		end else if (load) begin
			frame_q <= frame_d;
		end
	end

	// the shifter takes the new frame on the load cycle itself
	assign frame = load ? frame_d : frame_q;

endmodule

//--- src/uart_tx_shifter.sv
`include "uart_params.svh"

module uart_tx_shifter (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       load,        // copy a new frame
	input  logic                       bit_tick,    // move on to the next bit
	input  logic [`UART_FRAME_MAX-1:0] frame_bits,
	input  logic                       busy,
	output logic                       tx
);

	logic [`UART_FRAME_MAX-1:0] shreg;  // bit 0 is the bit on the line

	always_ff @(posedge clk) begin
		if (rst) begin
			shreg <= '1;
		end else if (load) begin
			shreg <= frame_bits;
		end else if (bit_tick) begin
			shreg <= {1'b1, shreg[`UART_FRAME_MAX-1:1]};  // stop level fills from the top
		end
	end

	// line follows the register one cycle late, idles high
	always_ff @(posedge clk) begin
		if (rst)
			tx <= 1'b1;
		else
			tx <= busy ? shreg[0] : 1'b1;
	end

endmodule

//--- src/uart_tx_top.sv
`include "uart_params.svh"

module uart_tx_top (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    en,        // start strobe
	input  logic [7:0]              data,
	input  uart_pkg::line_fmt_t     fmt,
	input  logic [`UART_BAUD_W-1:0] baud_div,  // hold stable while busy
	output logic                    tx,
	output logic                    busy,
	output logic                    ack
);

	logic             load;
	logic             run;
	logic             bit_tick;
	uart_pkg::frame_t frame;

	uart_baud_timer uart_baud_timer_i (
		.clk      (clk),
		.rst      (rst),
		.run      (run),
		.baud_div (baud_div),
		.bit_tick (bit_tick)
	);

	uart_tx_ctrl uart_tx_ctrl_i (
		.clk      (clk),
		.rst      (rst),
		.en       (en),
		.bit_tick (bit_tick),
		.last_bit (frame.last_bit),
		.load     (load),
		.run      (run),
		.busy     (busy),
		.ack      (ack)
	);

	uart_frame_builder uart_frame_builder_i (
		.clk   (clk),
		.rst   (rst),
		.load  (load),
		.data  (data),
		.fmt   (fmt),
		.frame (frame)
	);

	uart_tx_shifter uart_tx_shifter_i (
		.clk        (clk),
		.rst        (rst),
		.load       (load),
		.bit_tick   (bit_tick),
		.frame_bits (frame.bits),
		.busy       (busy),
		.tx         (tx)
	);

endmodule

//--- dv/uart_tx_tb.sv
`include "uart_params.svh"

module uart_tx_tb;

	localparam int CLK_PERIOD = 4;
	localparam int N_FRAMES   = 45;
	localparam int MAX_BIT    = `UART_CLK_DIV * 3 * `UART_SUBTICKS;  // bit period at baud_div 2
	localparam int TIMEOUT    = N_FRAMES * 12 * MAX_BIT * 2;

	logic                    clk;
	logic                    rst;
	logic                    en;
	logic [7:0]              data;
	uart_pkg::line_fmt_t     fmt;
	logic [`UART_BAUD_W-1:0] baud_div;
	logic                    tx;
	logic                    busy;
	logic                    ack;
	logic [31:0]             lcg_state;
	logic [7:0]              d;
	uart_pkg::line_fmt_t     f;
	int                      cycles;
	int                      ack_count;
	int                      starts;     // frames accepted by the DUT
	time                     ack_time;

	uart_tx_top uart_tx_top_i (
		.clk      (clk),
		.rst      (rst),
		.en       (en),
		.data     (data),
		.fmt      (fmt),
		.baud_div (baud_div),
		.tx       (tx),
		.busy     (busy),
		.ack      (ack)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("Simulation FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_value(input string test, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected)
		else stop_on_error($sformatf("FAIL %s expected %0h actual %0h",
			test, expected, actual));
	endtask

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [7:0] random_byte();
		logic [31:0] r;
		r = lcg_next();
		return r[31:24];  // upper byte of the generator state
	endfunction

	function automatic uart_pkg::line_fmt_t random_fmt();
		logic [31:0]         r;
		uart_pkg::line_fmt_t rf;
		r = lcg_next();
		rf.data_len  = uart_pkg::data_len_e'(r[25:24]);
		rf.stop_len  = (r[27:26] == 2'd3) ? uart_pkg::STOP2
			: uart_pkg::stop_len_e'(r[27:26]);
		rf.parity_en = r[28];
		rf.parity    = uart_pkg::parity_e'(r[30:29]);
		return rf;
	endfunction

	// odd and even count the ones over the sent data bits only
	function automatic logic expected_parity(input logic [7:0] v, input int n,
			input uart_pkg::parity_e par);
		int ones;
		ones = 0;
		for (int i = 0; i < n; i++)
			if (v[i])
				ones++;
		case (par)
			uart_pkg::PAR_ODD:  return (ones % 2) == 0;
			uart_pkg::PAR_EVEN: return (ones % 2) == 1;
			uart_pkg::PAR_MARK: return 1'b1;
			default:            return 1'b0;
		endcase
	endfunction

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic send_frame(input logic [7:0] dv, input uart_pkg::line_fmt_t fv);
		wait_cycles(1);
		while (busy)
			wait_cycles(1);
		en   = 1'b1;
		data = dv;
		fmt  = fv;
		starts++;
		wait_cycles(1);
		en = 1'b0;
	endtask

	// samples the line in the middle of each bit, from the start bit onwards
	task automatic decode_frame(input string test, input logic [7:0] dv,
			input uart_pkg::line_fmt_t fv, input bit check_high);
		int   period;
		int   n_data;
		int   frame_len;
		int   n_bits;
		int   acks_before;
		time  fall_time;
		logic exp;
		period      = `UART_CLK_DIV * (int'(baud_div) + 1) * `UART_SUBTICKS;
		n_data      = 8 - int'(fv.data_len);
		frame_len   = 1 + n_data + int'(fv.parity_en)
			+ ((fv.stop_len == uart_pkg::STOP1) ? 1 : 2);
		// idle where bits 5..7 would be
		n_bits      = (check_high && frame_len < 9) ? 9 : frame_len;
		acks_before = ack_count;
		@(negedge tx);
		fall_time = $time;
		for (int i = 0; i < n_bits; i++) begin
			#((i == 0) ? period * CLK_PERIOD / 2 + 1 : period * CLK_PERIOD);
			if (i == 0)
				exp = 1'b0;
			else if (i <= n_data)
				exp = dv[i-1];
			else if (fv.parity_en && i == n_data + 1)
				exp = expected_parity(dv, n_data, fv.parity);
			else
				exp = 1'b1;  // stop bits, then the idle line
			check_value($sformatf("%s bit %0d", test, i), exp, tx);
		end
		while (ack_count == acks_before)
			@(posedge clk);
		check_value({test, " frame bits"}, frame_len,
			int'((ack_time - fall_time + period * 2) / (period * CLK_PERIOD)));
		wait_cycles(1);
	endtask

	task automatic run_frame(input string test, input logic [7:0] dv,
			input uart_pkg::line_fmt_t fv, input bit check_high);
		send_frame(dv, fv);
		decode_frame(test, dv, fv, check_high);
		check_value({test, " acks"}, starts, ack_count);
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycles > TIMEOUT)
			stop_on_error($sformatf("timeout after %0d cycles with no end of test",
				cycles));
	end

	always @(negedge clk) begin
		if (!rst && ack) begin
			ack_count++;
			ack_time = $time;
		end
	end

	a_ack_pulse: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
		else stop_on_error("ack stayed high for more than one cycle");
	a_busy_drop: assert property (@(posedge clk) disable iff (rst) ack |=> !busy)
		else stop_on_error("busy did not fall on the cycle after ack");
	a_ack_busy: assert property (@(posedge clk) disable iff (rst) ack |-> busy)
		else stop_on_error("ack came while the transmitter was idle");
	a_start_bit: assert property (@(posedge clk) disable iff (rst) $rose(busy) |=> !tx)
		else stop_on_error("start bit did not follow busy by one cycle");
	a_idle_line: assert property (@(posedge clk) disable iff (rst) !busy |-> tx)
		else stop_on_error("tx left the idle level while not busy");
	a_accept: assert property (@(posedge clk) disable iff (rst) (!busy && en) |=> busy)
		else stop_on_error("en in idle did not raise busy");

	initial begin
		clk       = 1'b0;
		rst       = 1'b1;
		en        = 1'b0;
		data      = '0;
		fmt       = '0;
		baud_div  = '0;
		lcg_state = 32'hb7bb_d1b8;
		cycles    = 0;
		ack_count = 0;
		starts    = 0;
		ack_time  = 0;

		for (int k = 0; k < 20; k++) begin
			if (k == 16)
				rst = 1'b0;  // a few cycles checked after release too
			wait_cycles(1);
			check_value("reset tx", 1, tx);
			check_value("reset busy", 0, busy);
			check_value("reset ack", 0, ack);
		end

		for (int b = 0; b < 2; b++) begin
			baud_div = (b == 0) ? 8'd0 : 8'd2;
			for (int k = 0; k < 5; k++) begin
				f = '{uart_pkg::LEN8, uart_pkg::STOP1, 1'b0, uart_pkg::PAR_ODD};
				run_frame("8N1", random_byte(), f, 1'b0);
			end
		end

		baud_div = 8'd0;
		for (int l = 1; l < 4; l++) begin
			for (int k = 0; k < 4; k++) begin
				f           = random_fmt();
				f.data_len  = uart_pkg::data_len_e'(l[1:0]);
				f.parity_en = 1'b0;
				run_frame("short data", random_byte(), f, 1'b1);
			end
		end

		for (int p = 0; p < 4; p++) begin
			for (int k = 0; k < 4; k++) begin
				f           = random_fmt();
				f.parity_en = 1'b1;
				f.parity    = uart_pkg::parity_e'(p[1:0]);
				run_frame("parity", random_byte(), f, 1'b0);
			end
		end

		for (int s = 1; s < 3; s++) begin
			for (int k = 0; k < 3; k++) begin
				f          = random_fmt();
				f.stop_len = uart_pkg::stop_len_e'(s[1:0]);
				run_frame("stop length", random_byte(), f, 1'b0);
			end
		end

		// new strobes and inputs in flight must not touch the frame
		d = random_byte();
		f = '{uart_pkg::LEN8, uart_pkg::STOP2, 1'b1, uart_pkg::PAR_EVEN};
		send_frame(d, f);
		fork
			decode_frame("ignored start", d, f, 1'b0);
			begin
				repeat (3) begin
					wait_cycles(30);
					check_value("ignored start busy", 1, busy);
					en   = 1'b1;
					data = random_byte();
					fmt  = random_fmt();
					wait_cycles(1);
					en = 1'b0;
				end
			end
		join
		wait_cycles(8);
		check_value("ignored start idle", 0, busy);
		check_value("ignored start acks", starts, ack_count);

		$display("Simulation PASSED");
		$finish;
	end

endmodule

//--- list.f
+incdir+src
src/uart_pkg.sv
src/uart_baud_timer.sv
src/uart_tx_ctrl.sv
src/uart_frame_builder.sv
src/uart_tx_shifter.sv
src/uart_tx_top.sv
dv/uart_tx_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= uart_tx_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= list.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(filter-out +%,$(shell cat $(FILELIST))) src/uart_params.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)
